//--- lsuPkg.sv
/*
 * Load/store unit shared definitions
 * Data word and byte mask types, access size and fault codes,
 * and the rule that decides which accesses fault
 */
package lsuPkg;

  localparam int dataWidth = 32;             // Data word width in bits
  localparam int maskWidth = dataWidth / 8;  // Bytes per word

  typedef logic [dataWidth-1:0] wordT;       // One data word
  typedef logic [maskWidth-1:0] byteMaskT;   // One write enable per byte lane
  typedef logic [1:0]           offsetT;     // Byte offset within a word

  // Access size in RISC-V funct3 coding
  // Codes 3, 6 and 7 have no name and are illegal
  typedef enum logic [2:0] {
    sizeByte  = 3'd0,
    sizeHalf  = 3'd1,
    sizeWord  = 3'd2,
    sizeByteU = 3'd4,
    sizeHalfU = 3'd5
  } memSizeE;

  // Result status of one access
  typedef enum logic [1:0] {
    faultNone        = 2'd0,
    faultMisaligned  = 2'd1,
    faultIllegalSize = 2'd2
  } faultE;

  // Illegal size wins over misalignment
  function automatic faultE accessFault(memSizeE size, offsetT offset);
    faultE result;
    case (size)
      sizeByte, sizeByteU: result = faultNone;                                   // Any offset
      sizeHalf, sizeHalfU: result = offset[0] ? faultMisaligned : faultNone;    // Even only
      sizeWord:            result = (offset != 2'b00) ? faultMisaligned : faultNone;
      default:             result = faultIllegalSize;                           // Codes 3, 6, 7
    endcase
    return result;
  endfunction

endpackage

//--- memReqIf.sv
/*
 * Aligned memory request
 * Carries lane-placed store data, byte mask and access details
 * from the store-alignment stage to the data memory
 */
interface memReqIf import lsuPkg::*; ();

  logic                 valid;      // Request present
  logic                 ready;      // Memory can take it
  logic                 write;      // Store when high, load when low
  logic [dataWidth-3:0] wordIdx;    // Full word address
  wordT                 data;       // Store data already in its lanes
  byteMaskT             byteMask;   // Bytes to write, empty on fault
  memSizeE              size;       // Access size for the load stage
  offsetT               offset;     // Byte offset for the load stage
  logic                 bigEndian;  // Byte order of this access
  faultE                fault;      // Fault found by the request stage

  // Request stage side
  modport producer (
    output valid, write, wordIdx, data, byteMask, size, offset, bigEndian, fault,
    input  ready
  );

  // Data memory side
  modport memory (
    input  valid, write, wordIdx, data, byteMask, size, offset, bigEndian, fault,
    output ready
  );

endinterface

//--- memRspIf.sv
/*
 * Raw memory response
 * Carries the addressed word and the access details that the
 * load-extract stage needs to pick out the value
 */
interface memRspIf import lsuPkg::*; ();

  logic    valid;      // Response present
  logic    ready;      // Load stage can take it
  logic    write;      // Response belongs to a store
  wordT    data;       // Whole memory word, zero for stores and faults
  memSizeE size;
  offsetT  offset;
  logic    bigEndian;
  faultE   fault;

  modport memory (
    output valid, write, data, size, offset, bigEndian, fault,
    input  ready
  );

  modport consumer (
    input  valid, write, data, size, offset, bigEndian, fault,
    output ready
  );

endinterface

//--- storeAlign.sv
/*
 * Store alignment stage
 * Checks size and alignment, builds the byte write mask and places
 * the store data into its byte lanes, then registers the request
 */
module storeAlign import lsuPkg::*; (
  input  logic      clk,
  input  logic      arstN,
  input  logic      reqValid,
  input  logic      reqWrite,
  input  logic [31:0] reqAdr,    // Byte address
  input  wordT      reqData,
  input  memSizeE   reqSize,
  input  logic      reqBigEndian,
  output logic      reqReady,
  memReqIf.producer memReq
);

  offsetT   offset;       // Byte within the word
  faultE    fault;
  byteMaskT baseMask;     // Mask of an access at offset 0
  byteMaskT byteMask;
  wordT     orderedData;  // Accessed bytes in memory order
  wordT     laneData;     // Data replicated across the lanes
  logic     accept;

  ////////////////////////////////////////////////////////////////////////////
  // Access check and byte mask
  ////////////////////////////////////////////////////////////////////////////

  assign offset = reqAdr[1:0];
  assign fault  = accessFault(reqSize, offset);

  always_comb begin
    case (reqSize[1:0])                 // Unsigned codes share the low bits
      2'd0:    baseMask = 4'b0001;
      2'd1:    baseMask = 4'b0011;
      default: baseMask = 4'b1111;      // Word and the illegal codes that fault
    endcase
  end

  assign byteMask = (fault == faultNone) ? byteMaskT'(baseMask << offset) : '0;

  ////////////////////////////////////////////////////////////////////////////
  // Endian swap and lane placement
  ////////////////////////////////////////////////////////////////////////////

  // Big endian reverses only the bytes that are accessed
  always_comb begin
    orderedData = reqData;
    if (reqBigEndian) begin
      case (reqSize[1:0])
        2'd1:    orderedData = {reqData[31:16], reqData[7:0], reqData[15:8]};
        2'd2:    orderedData = {reqData[7:0], reqData[15:8], reqData[23:16], reqData[31:24]};
        default: orderedData = reqData;                // Single byte has no order
      endcase
    end
  end

  // Copy into every lane so the mask alone picks the target bytes
  always_comb begin
    case (reqSize[1:0])
      2'd0:    laneData = {4{orderedData[7:0]}};
      2'd1:    laneData = {2{orderedData[15:0]}};
      default: laneData = orderedData;
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // Output register
  ////////////////////////////////////////////////////////////////////////////

  assign reqReady = ~memReq.valid | memReq.ready;  // Empty or draining this cycle
  assign accept   = reqValid & reqReady;

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      memReq.valid <= 1'b0;
    end else if (reqReady) begin
      memReq.valid <= reqValid;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      memReq.write     <= reqWrite;
      memReq.wordIdx   <= reqAdr[dataWidth-1:2];   // Drop the byte offset
      memReq.data      <= laneData;
      memReq.byteMask  <= byteMask;
      memReq.size      <= reqSize;
      memReq.offset    <= offset;
      memReq.bigEndian <= reqBigEndian;
      memReq.fault     <= fault;
    end
  end

  // A clean store must reach the memory with at least one byte enabled
  aWriteMask: assert property (@(posedge clk) disable iff (!arstN)
    memReq.valid && memReq.write && (memReq.fault == faultNone) |-> memReq.byteMask != '0);

endmodule

//--- dataTim.sv
/*
 * Tightly integrated data memory
 * Word-addressed array with byte-masked writes and a registered
 * read word, higher addresses alias onto the array
 */
module dataTim import lsuPkg::*; #(
  parameter int DtimWords = 256          // Depth in words
) (
  input  logic    clk,
  input  logic    arstN,
  memReqIf.memory memReq,
  memRspIf.memory memRsp
);

  localparam int idxWidth = $clog2(DtimWords);

  wordT                mem [DtimWords];  // Storage array
  logic [idxWidth-1:0] idx;              // Word within the array
  logic                accept;
  byteMaskT            byteWe;           // Per byte write enable

  ////////////////////////////////////////////////////////////////////////////
  // Address and write enables
  ////////////////////////////////////////////////////////////////////////////

  assign idx    = idxWidth'(memReq.wordIdx % DtimWords);  // Alias modulo depth
  assign accept = memReq.valid & memReq.ready;

  // Faulted requests carry an empty mask from the request stage
  assign byteWe = (accept && memReq.write) ? memReq.byteMask : '0;

  always_ff @(posedge clk) begin
    for (int b = 0; b < maskWidth; b++) begin
      if (byteWe[b]) begin
        mem[idx][8*b +: 8] <= memReq.data[8*b +: 8];
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Response register
  ////////////////////////////////////////////////////////////////////////////

  assign memReq.ready = ~memRsp.valid | memRsp.ready;

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      memRsp.valid <= 1'b0;
    end else if (memReq.ready) begin
      memRsp.valid <= memReq.valid;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      // Stores and faults return zero so the load stage has nothing to mask
      if (memReq.write || (memReq.fault != faultNone)) begin
        memRsp.data <= '0;
      end else begin
        memRsp.data <= mem[idx];            // Old word since loads never write
      end
      memRsp.write     <= memReq.write;
      memRsp.size      <= memReq.size;
      memRsp.offset    <= memReq.offset;
      memRsp.bigEndian <= memReq.bigEndian;
      memRsp.fault     <= memReq.fault;
    end
  end

  // Request stage must clear the mask of every faulted access
  aFaultNoWrite: assert property (@(posedge clk) disable iff (!arstN)
    memReq.valid && (memReq.fault != faultNone) |-> memReq.byteMask == '0);

  // Held response under back-pressure
  aRspStable: assert property (@(posedge clk) disable iff (!arstN)
    memRsp.valid && !memRsp.ready |=> memRsp.valid && $stable(memRsp.data)
      && $stable(memRsp.write) && $stable(memRsp.fault));

endmodule

//--- loadExtract.sv
/*
 * Load extraction stage
 * Picks the addressed bytes from the memory word, restores byte
 * order, extends by size and drives the response port
 */
module loadExtract import lsuPkg::*; (
  input  logic      clk,
  input  logic      arstN,
  memRspIf.consumer memRsp,
  output logic      rspValid,
  output wordT      rspData,
  output logic      rspWrite,
  output faultE     rspFault,
  input  logic      rspReady
);

  wordT shifted;    // Addressed byte moved to lane 0
  wordT raw;        // Accessed bytes in value order, upper bits zero
  wordT loadValue;  // Extended result
  logic accept;

  ////////////////////////////////////////////////////////////////////////////
  // Byte selection and endian swap
  ////////////////////////////////////////////////////////////////////////////

  assign shifted = memRsp.data >> {memRsp.offset, 3'b000};

  always_comb begin
    case (memRsp.size[1:0])
      2'd0: raw = {{(dataWidth-8){1'b0}}, shifted[7:0]};
      2'd1: begin
        if (memRsp.bigEndian) begin
          raw = {{(dataWidth-16){1'b0}}, shifted[7:0], shifted[15:8]};  // Low lane is MSB
        end else begin
          raw = {{(dataWidth-16){1'b0}}, shifted[15:0]};
        end
      end
      default: begin
        if (memRsp.bigEndian) begin
          raw = {shifted[7:0], shifted[15:8], shifted[23:16], shifted[31:24]};
        end else begin
          raw = shifted;
        end
      end
    endcase
  end

  // Sign extension for the signed codes
  always_comb begin
    case (memRsp.size)
      sizeByte:  loadValue = {{(dataWidth-8){raw[7]}}, raw[7:0]};
      sizeByteU: loadValue = {{(dataWidth-8){1'b0}}, raw[7:0]};
      sizeHalf:  loadValue = {{(dataWidth-16){raw[15]}}, raw[15:0]};
      sizeHalfU: loadValue = {{(dataWidth-16){1'b0}}, raw[15:0]};
      sizeWord:  loadValue = raw;
      default:   loadValue = '0;        // Illegal size is faulted
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // Output register
  ////////////////////////////////////////////////////////////////////////////

  assign memRsp.ready = ~rspValid | rspReady;
  assign accept       = memRsp.valid & memRsp.ready;

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      rspValid <= 1'b0;
    end else if (memRsp.ready) begin
      rspValid <= memRsp.valid;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      rspData  <= loadValue;
      rspWrite <= memRsp.write;   // Forwarded as is
      rspFault <= memRsp.fault;
    end
  end

  // Response held until the sink takes it
  aRspHold: assert property (@(posedge clk) disable iff (!arstN)
    rspValid && !rspReady |=> rspValid && $stable(rspData)
      && $stable(rspWrite) && $stable(rspFault));

endmodule

//--- lsuTop.sv
/*
 * Load/store unit top level
 * Store alignment, data memory and load extraction in a
 * three-stage valid/ready pipeline
 */
module lsuTop import lsuPkg::*; #(
  parameter int DtimWords = 256
) (
  input  logic        clk,
  input  logic        arstN,
  // Request port
  input  logic        reqValid,
  output logic        reqReady,
  input  logic        reqWrite,
  input  logic [31:0] reqAdr,
  input  wordT        reqData,
  input  memSizeE     reqSize,
  input  logic        reqBigEndian,
  // Response port
  output logic        rspValid,
  input  logic        rspReady,
  output wordT        rspData,
  output logic        rspWrite,
  output faultE       rspFault
);

  memReqIf memReq ();   // Align stage to memory
  memRspIf memRsp ();   // Memory to extract stage

  storeAlign uStoreAlign (
    .clk          (clk),
    .arstN        (arstN),
    .reqValid     (reqValid),
    .reqWrite     (reqWrite),
    .reqAdr       (reqAdr),
    .reqData      (reqData),
    .reqSize      (reqSize),
    .reqBigEndian (reqBigEndian),
    .reqReady     (reqReady),
    .memReq       (memReq.producer)
  );

  dataTim #(.DtimWords(DtimWords)) uDataTim (
    .clk    (clk),
    .arstN  (arstN),
    .memReq (memReq.memory),
    .memRsp (memRsp.memory)
  );

  loadExtract uLoadExtract (
    .clk      (clk),
    .arstN    (arstN),
    .memRsp   (memRsp.consumer),
    .rspValid (rspValid),
    .rspData  (rspData),
    .rspWrite (rspWrite),
    .rspFault (rspFault),
    .rspReady (rspReady)
  );

endmodule

//--- tbClock.sv
/*
 * Testbench clock and reset
 * 8 ns clock, reset held low for the first three rising edges
 */
module tbClock (
  output logic clk,
  output logic arstN
);
  timeunit 1ns;
  timeprecision 100ps;

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;           // Half of the 8 ns period
  end

  initial begin
    arstN <= 1'b0;
    repeat (3) @(posedge clk);
    arstN <= 1'b1;                   // Released on the third edge
  end

endmodule

//--- tbLsu.sv
/*
 * Load/store unit testbench
 * Random loads and stores checked against a byte-array memory model,
 * with fault cases, response back-pressure and request gaps
 */
module tbLsu import lsuPkg::*; ();
  timeunit 1ns;
  timeprecision 100ps;

  localparam int waitLimit = 200;       // Cycles per wait before giving up

  logic        clk, arstN;
  logic        reqValid, reqReady, reqWrite, reqBigEndian;
  logic [31:0] reqAdr;
  wordT        reqData, rspData;
  memSizeE     reqSize;
  logic        rspValid, rspReady, rspWrite;
  faultE       rspFault;

  integer seed       = 74;
  int     errCount   = 0;
  int     checkCount = 0;
  int     rspCount   = 0;
  logic   throttle   = 1'b0;            // Random rspReady
  logic   gaps       = 1'b0;            // Random idle cycles between requests

  logic [7:0]  model [256];             // Byte image that aliases like the DUT
  logic [68:0] stimQ [$];               // {write, adr, data, size, bigEndian}
  wordT        expData [$];
  logic        expWrite [$];
  faultE       expFault [$];

  tbClock uClock (.clk(clk), .arstN(arstN));

  lsuTop #(.DtimWords(64)) dut (.*);

  ////////////////////////////////////////////////////////////////////////////
  // Compare tasks
  ////////////////////////////////////////////////////////////////////////////

  task automatic checkData(string name, wordT got, wordT exp);
    checkCount++;
    if (got !== exp) begin
      $display("FAIL %0t %s got %h expected %h", $time, name, got, exp);
      errCount++;
    end
  endtask

  task automatic checkFault(string name, faultE got, faultE exp);
    checkCount++;
    if (got !== exp) begin
      $display("FAIL %0t %s got %0d expected %0d", $time, name, got, exp);
      errCount++;
    end
  endtask

  task automatic checkWrite(string name, logic got, logic exp);
    checkCount++;
    if (got !== exp) begin
      $display("FAIL %0t %s got %b expected %b", $time, name, got, exp);
      errCount++;
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Memory model and stimulus
  ////////////////////////////////////////////////////////////////////////////

  function automatic logic coin();
    return 1'($random(seed));
  endfunction

  // Expected response of one accepted request, applied in request order
  task automatic modelAccess(logic w, logic [31:0] adr, wordT d, memSizeE sz, logic be);
    int         n;
    logic [7:0] a;
    wordT       value;
    faultE      f;
    value = '0;                          // Stores and faults return zero
    case (sz)
      sizeByte, sizeByteU: n = 1;
      sizeHalf, sizeHalfU: n = 2;
      default:             n = 4;
    endcase
    if (!(sz inside {sizeByte, sizeByteU, sizeHalf, sizeHalfU, sizeWord})) begin
      f = faultIllegalSize;              // Codes 3, 6 and 7
    end else if ((int'(adr[1:0]) % n) != 0) begin
      f = faultMisaligned;               // Not on a multiple of the access width
    end else begin
      f = faultNone;
    end
    if (f == faultNone) begin
      for (int i = 0; i < n; i++) begin
        a = be ? 8'(adr + 32'(n - 1 - i)) : 8'(adr + 32'(i));  // Big endian puts byte 0 on top
        if (w) begin
          model[a] = d[8*i +: 8];
        end else begin
          value[8*i +: 8] = model[a];
        end
      end
      if (!w && sz == sizeByte) value = {{24{value[7]}}, value[7:0]};
      if (!w && sz == sizeHalf) value = {{16{value[15]}}, value[15:0]};
    end
    expData.push_back(value);
    expWrite.push_back(w);
    expFault.push_back(f);
  endtask

  task automatic addReq(logic w, logic [31:0] adr, wordT d, memSizeE sz, logic be);
    stimQ.push_back({w, adr, d, sz, be});
  endtask

  // Holds the request until reqReady is seen at an edge
  task automatic sendReq(logic w, logic [31:0] adr, wordT d, memSizeE sz, logic be);
    int   cycles;
    logic taken;
    reqValid     <= 1'b1;
    reqWrite     <= w;
    reqAdr       <= adr;
    reqData      <= d;
    reqSize      <= sz;
    reqBigEndian <= be;
    cycles = 0;
    taken  = 1'b0;
    while (!taken && cycles < waitLimit) begin
      @(posedge clk);
      taken = reqReady;                  // Value before this edge's updates
      cycles++;
    end
    if (taken) begin
      modelAccess(w, adr, d, sz, be);
    end else begin
      $display("Request to %h was not accepted within %0d cycles", adr, waitLimit);
      errCount++;
    end
  endtask

  task automatic driveAll();
    logic        w;
    logic [31:0] adr;
    wordT        d;
    logic [2:0]  sz;
    logic        be;
    while (stimQ.size() > 0) begin
      {w, adr, d, sz, be} = stimQ.pop_front();
      if (gaps && coin()) begin
        reqValid <= 1'b0;                // One idle cycle
        @(posedge clk);
      end
      sendReq(w, adr, d, memSizeE'(sz), be);
    end
    reqValid <= 1'b0;
  endtask

  task automatic collectAll(int total);
    int   cycles;
    logic got;
    for (int k = 0; k < total; k++) begin
      cycles = 0;
      got    = 1'b0;
      while (!got && cycles < waitLimit) begin
        @(posedge clk);
        got = rspValid && rspReady;      // Transfer at this edge
        rspReady <= throttle ? coin() : 1'b1;
        cycles++;
      end
      if (!got) begin
        $display("Response %0d of %0d missing after %0d cycles", k + 1, total, waitLimit);
        errCount++;
        break;
      end
      rspCount++;
      if (expData.size() == 0) begin
        $display("Response at %0t arrived with no request outstanding", $time);
        errCount++;
      end else begin
        checkData("rspData", rspData, expData.pop_front());
        checkWrite("rspWrite", rspWrite, expWrite.pop_front());
        checkFault("rspFault", rspFault, expFault.pop_front());
      end
    end
  endtask

  task automatic runQueued();
    int total;
    total = stimQ.size();
    fork
      driveAll();
      collectAll(total);
    join
    rspReady <= 1'b1;
    repeat (3) @(posedge clk);                // Quiet period
    checkWrite("rspValid", rspValid, 1'b0);   // No extra response
  endtask

  task automatic reportTest(string name, int errBefore);
    $display("%s: %s, %0d errors", name, (errCount == errBefore) ? "pass" : "fail",
             errCount - errBefore);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    int          errBefore;
    int          cycles;
    logic [31:0] adr;
    logic [2:0]  code;
    memSizeE     sz;
    reqValid     <= 1'b0;
    reqWrite     <= 1'b0;
    reqAdr       <= '0;
    reqData      <= '0;
    reqSize      <= sizeWord;
    reqBigEndian <= 1'b0;
    rspReady     <= 1'b1;

    errBefore = errCount;
    cycles    = 0;
    while (!arstN && cycles < waitLimit) begin
      @(posedge clk);
      cycles++;
    end
    if (!arstN) begin
      $display("Reset was never released");
      errCount++;
    end
    checkWrite("rspValid", rspValid, 1'b0);
    checkWrite("reqReady", reqReady, 1'b1);
    reportTest("reset state", errBefore);

    // Every word stored, then loaded back through another alias
    errBefore = errCount;
    for (int i = 0; i < 128; i++) begin
      adr = ({$random(seed)} & 32'hFFFF_FF00) | (32'(i % 64) << 2);
      addReq(i < 64, adr, $random(seed), sizeWord, 1'b0);
    end
    runQueued();
    reportTest("word round-trip", errBefore);

    errBefore = errCount;
    for (int i = 0; i < 300; i++) begin
      code = 3'({$random(seed)} % 5);
      sz   = memSizeE'((code >= 3'd3) ? code + 3'd1 : code);   // Legal codes only
      adr  = $random(seed);
      if (sz inside {sizeHalf, sizeHalfU}) adr[0] = 1'b0;
      if (sz == sizeWord) adr[1:0] = 2'b00;
      addReq(coin(), adr, $random(seed), sz, coin());
    end
    runQueued();
    reportTest("aligned mix", errBefore);

    // Faulted access, then a word load of the same word
    errBefore = errCount;
    for (int i = 0; i < 40; i++) begin
      adr  = $random(seed);
      code = 3'({$random(seed)} % 3);
      case (code)
        3'd0: begin
          sz     = coin() ? sizeHalf : sizeHalfU;
          adr[0] = 1'b1;
        end
        3'd1: begin
          sz       = sizeWord;
          adr[1:0] = 2'(1 + {$random(seed)} % 3);
        end
        default: sz = memSizeE'(coin() ? 3'd3 : (coin() ? 3'd6 : 3'd7));
      endcase
      addReq(coin(), adr, $random(seed), sz, coin());
      addReq(1'b0, adr & ~32'h3, '0, sizeWord, 1'b0);
    end
    runQueued();
    reportTest("faults", errBefore);

    // Any size at any address, with stalls on both sides
    errBefore = errCount;
    throttle  = 1'b1;
    gaps      = 1'b1;
    for (int i = 0; i < 400; i++) begin
      addReq(coin(), $random(seed), $random(seed), memSizeE'(3'($random(seed))), coin());
    end
    runQueued();
    reportTest("back-pressure", errBefore);

    $display("%0d responses, %0d checks, %0d errors", rspCount, checkCount, errCount);
    if (errCount == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

//--- vlog.f
lsuPkg.sv
memReqIf.sv
memRspIf.sv
storeAlign.sv
dataTim.sv
loadExtract.sv
lsuTop.sv
tbClock.sv
tbLsu.sv

//--- Makefile
TOOL     = verilator
FLAGS    = --binary --assert -j 0
TOP      = tbLsu
FILELIST = vlog.f
LOG      = sim.log

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -qx "Test OK" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
